// File: Bender.yml
package:
  name: mera_pa

dependencies: {}

sources:
  - files:
      - source/mera_pa_pkg.sv
      - source/pa_dp_if.sv
      - source/pa_bus_mux.sv
      - source/pa_alu.sv
      - source/pa_regs.sv
      - source/pa_control.sv
      - source/mera_pa_top.sv
  - target: test
    files:
      - dv/mera_pa_sva.sv
      - dv/mera_pa_tb.sv

// File: dv/mera_pa_sva.sv
/*
	credit and handshake properties for pa_control
	bound into every pa_control instance
	inactive while reset is high
*/
`timescale 1ns/1ps

module mera_pa_sva (
	input logic __ic_cu,
	input logic __ic_load,
	input logic cmd_valid,
	input logic res_valid,
	input logic res_credit,
	input logic [mera_pa_pkg::RES_CNT_W-1:0] res_cnt,
	input logic [mera_pa_pkg::CMD_CNT_W-1:0] buf_cnt
);

	int credit_cnt;

	// result credits held by the DUT, counted from the channel wires alone
	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load)
			credit_cnt <= mera_pa_pkg::RES_CREDITS;
		else
			credit_cnt <= credit_cnt - (res_valid ? 1 : 0) + (res_credit ? 1 : 0);
	end

	// no result goes out without a credit
	res_needs_credit: assert property (@(posedge __ic_cu) disable iff (__ic_load)
		res_valid |-> (credit_cnt > 0))
		else $error("res_valid asserted with no result credit");

	res_cnt_bound: assert property (@(posedge __ic_cu) disable iff (__ic_load)
		int'(res_cnt) <= mera_pa_pkg::RES_CREDITS)
		else $error("result credit counter above its reset value");

	// a credit-respecting sender never finds the buffer full
	cmd_room: assert property (@(posedge __ic_cu) disable iff (__ic_load)
		cmd_valid |-> (int'(buf_cnt) < mera_pa_pkg::CMD_DEPTH))
		else $error("command arrived with the buffer full");

endmodule

bind pa_control mera_pa_sva sva_i (
	.__ic_cu(__ic_cu), .__ic_load(__ic_load), .cmd_valid(cmd_valid),
	.res_valid(res_valid), .res_credit(res_credit), .res_cnt(res_cnt), .buf_cnt(buf_cnt)
);

// File: dv/mera_pa_tb.sv
/*
	testbench for the P-A unit, credit sender and receiver around the DUT
	expected results come from a shadow register model in issue order
	receiver stalls for long stretches to exercise back-pressure
*/
`timescale 1ns/1ps

module mera_pa_tb;

	logic __ic_cu;
	logic __ic_load;
	logic cmd_valid;
	mera_pa_pkg::cmd_t cmd;
	logic cmd_credit;
	logic res_valid;
	mera_pa_pkg::res_t res;
	logic res_credit;

	mera_pa_pkg::cmd_t cmd_list [$];
	mera_pa_pkg::res_t exp_q [$];
	logic [31:0] lcg_state = 32'h8fc7a0f0;
	logic [15:0] m_ac, m_at, m_ar, m_ic;
	int credits, sent, n_checked, owed, wait_cnt, n_credited;
	bit list_ready;

	mera_pa_top mera_pa_top_i (
		.__ic_cu(__ic_cu), .__ic_load(__ic_load), .cmd_valid(cmd_valid), .cmd(cmd),
		.cmd_credit(cmd_credit), .res_valid(res_valid), .res(res), .res_credit(res_credit)
	);

	always #5 __ic_cu = ~__ic_cu;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic mera_pa_pkg::cmd_t make_cmd(input mera_pa_pkg::pa_op_e op,
		input logic [3:0] fn, input logic arith, input logic cin, input logic [1:0] asrc,
		input logic aref, input logic eat0, input logic barnb, input logic [15:0] opnd);
		mera_pa_pkg::cmd_t c;
		c = '0;
		c.op = op;
		c.fn = fn;
		c.arith = arith;
		c.cin = cin;
		c.asrc = asrc;
		c.aref = aref;
		c.eat0 = eat0;
		c.barnb = barnb;
		c.operand = opnd;
		return c;
	endfunction

	// expected result, shadow registers advance in issue order
	function automatic mera_pa_pkg::res_t pa_model(input mera_pa_pkg::cmd_t c);
		logic [15:0] a, v, opnd;
		logic [16:0] sum;
		mera_pa_pkg::res_t r;
		r = '0;
		v = '0;
		sum = '0;
		opnd = c.operand;
		case (c.asrc)
			mera_pa_pkg::ASRC_L: a = opnd;
			mera_pa_pkg::ASRC_IC: a = m_ic;
			mera_pa_pkg::ASRC_AR: a = m_ar;
			default: a = {opnd[7:0], 8'h00};
		endcase
		case (c.op)
			mera_pa_pkg::op_ld_ac, mera_pa_pkg::op_ld_ar, mera_pa_pkg::op_ld_ic: begin
				v = c.fn[2] ? {8'h00, m_ac[15:8]} : opnd;
				if (c.fn[0])
					v[7:0] = 8'h00;
				if (c.fn[1])
					v[15:8] = 8'h00;
				if (c.op == mera_pa_pkg::op_ld_ac)
					m_ac = v;
				else if (c.op == mera_pa_pkg::op_ld_ar)
					m_ar = v;
				else
					m_ic = v;
			end
			mera_pa_pkg::op_alu, mera_pa_pkg::op_alu_at: begin
				case ({c.arith, c.fn})
					5'b1_1001: sum = {1'b0, a} + {1'b0, m_ac} + c.cin;
					5'b1_0110: sum = {1'b0, a} + {1'b0, ~m_ac} + c.cin;
					5'b0_1011: sum = {1'b0, a & m_ac};
					5'b0_1110: sum = {1'b0, a | m_ac};
					5'b0_0110: sum = {1'b0, a ^ m_ac};
					5'b0_0000: sum = {1'b0, ~a};
					default: sum = '0;
				endcase
				v = sum[15:0];
				r.carry = sum[16];
				r.j = &v;
				if (c.op == mera_pa_pkg::op_alu_at)
					m_at = v;
			end
			mera_pa_pkg::op_shr_at: begin
				v = {c.eat0, m_at[15:1]};
				m_at = v;
			end
			mera_pa_pkg::op_ar_inc: begin
				m_ar = m_ar + 16'd1;
				v = m_ar;
			end
			mera_pa_pkg::op_ar_dec4: begin
				m_ar = m_ar - 16'd4;
				v = m_ar;
			end
			mera_pa_pkg::op_ic_inc: begin
				m_ic = m_ic + 16'd1;
				v = m_ic;
			end
			default: begin
				v = c.aref ? m_ar : m_ic;
				r.zga = (c.barnb == opnd[15]) && (opnd[14:0] == v[14:0]);
			end
		endcase
		r.value = v;
		r.zs = |v;
		r.s0 = v[15];
		return r;
	endfunction

	task automatic build_tests();
		logic [3:0] fns [6] = '{4'b1001, 4'b0110, 4'b1011, 4'b1110, 4'b0110, 4'b0000};
		logic ariths [6] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
		logic [15:0] r16;
		// loads, byte blanks and the AC high byte source
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ld_ac, 4'h0, 0, 0, 0, 0, 0, 0, 16'h1234));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ld_ar, 4'h1, 0, 0, 0, 0, 0, 0, 16'hbeef));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ld_ic, 4'h2, 0, 0, 0, 0, 0, 0, 16'hcafe));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ld_ar, 4'h4, 0, 0, 0, 0, 0, 0, 16'h0000));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ld_ic, 4'h0, 0, 0, 0, 0, 0, 0, 16'h8001));
		// every ALU function with every A source and both carries
		for (int k = 0; k < 6; k++)
			for (int s = 0; s < 4; s++)
				for (int ci = 0; ci < 2; ci++) begin
					r16 = 16'(next_rand() >> 16);
					cmd_list.push_back(make_cmd(mera_pa_pkg::op_alu, fns[k], ariths[k],
						ci[0], s[1:0], 0, 0, 0, r16));
				end
		// A equals AC under subtract
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_alu, 4'b0110, 1, 0, 0, 0, 0, 0, 16'h1234));
		// AT path
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_alu_at, 4'b1001, 1, 1, 0, 0, 0, 0, 16'h7f0f));
		for (int k = 0; k < 4; k++)
			cmd_list.push_back(make_cmd(mera_pa_pkg::op_shr_at, 0, 0, 0, 0, 0, k[0], 0, 0));
		// counters wrapping
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ld_ar, 4'h0, 0, 0, 0, 0, 0, 0, 16'h0001));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ar_dec4, 0, 0, 0, 0, 0, 0, 0, 0));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ld_ar, 4'h0, 0, 0, 0, 0, 0, 0, 16'hffff));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ar_inc, 0, 0, 0, 0, 0, 0, 0, 0));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ld_ic, 4'h0, 0, 0, 0, 0, 0, 0, 16'hffff));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_ic_inc, 0, 0, 0, 0, 0, 0, 0, 0));
		// address compare, matching then mismatching keys
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_cmp_addr, 0, 0, 0, 0, 0, 0, 1, 16'h8000));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_cmp_addr, 0, 0, 0, 0, 1, 0, 0, 16'h0000));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_cmp_addr, 0, 0, 0, 0, 1, 0, 1, 16'h0000));
		cmd_list.push_back(make_cmd(mera_pa_pkg::op_cmp_addr, 0, 0, 0, 0, 0, 0, 1, 16'h8001));
		// random mix of counter steps and compares
		for (int k = 0; k < 30; k++) begin
			r16 = 16'(next_rand() >> 16);
			cmd_list.push_back(make_cmd(mera_pa_pkg::pa_op_e'(4'd5 + (r16[14:12] % 3'd5)),
				0, 0, 0, 0, r16[0], r16[1], r16[2], r16));
		end
	endtask

	task automatic check_field(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else begin
			$display("ERROR %s: got %h expected %h (result %0d)", name, got, exp, n_checked);
			$display("Some tests failed");
			$fatal(1, "result mismatch");
		end
	endtask

	// command sender, one command per credit
	always @(posedge __ic_cu) begin
		if (__ic_load) begin
			cmd_valid <= 1'b0;
			credits = mera_pa_pkg::CMD_DEPTH;
		end else begin
			if (cmd_credit)
				credits++;
			cmd_valid <= 1'b0;
			if (credits > 0 && sent < cmd_list.size()) begin
				cmd_valid <= 1'b1;
				cmd <= cmd_list[sent];
				exp_q.push_back(pa_model(cmd_list[sent]));
				credits--;
				sent++;
			end
			assert (credits >= 0 && credits <= mera_pa_pkg::CMD_DEPTH)
			else begin
				$display("command credits out of range, the DUT returned too many");
				$display("Some tests failed");
				$fatal(1, "credit error");
			end
		end
	end

	// result receiver, random delays and two long stalls
	always @(posedge __ic_cu) begin
		if (__ic_load) begin
			res_credit <= 1'b0;
			owed = 0;
			wait_cnt = 0;
			n_credited = 0;
		end else begin
			res_credit <= 1'b0;
			if (res_valid)
				owed++;
			if (owed > 0) begin
				if (wait_cnt > 0) begin
					wait_cnt--;
				end else begin
					res_credit <= 1'b1;
					owed--;
					n_credited++;
					wait_cnt = (n_credited == 20 || n_credited == 60) ? 60 : next_rand() % 4;
				end
			end
		end
	end

	// comparison against the model
	always @(posedge __ic_cu) begin
		mera_pa_pkg::res_t e;
		if (!__ic_load && res_valid) begin
			assert (exp_q.size() > 0)
			else begin
				$display("result arrived with no command outstanding");
				$display("Some tests failed");
				$fatal(1, "extra result");
			end
			e = exp_q.pop_front();
			check_field("res.value", res.value, e.value);
			check_field("res.carry", 16'(res.carry), 16'(e.carry));
			check_field("res.zs", 16'(res.zs), 16'(e.zs));
			check_field("res.s0", 16'(res.s0), 16'(e.s0));
			check_field("res.j", 16'(res.j), 16'(e.j));
			check_field("res.zga", 16'(res.zga), 16'(e.zga));
			n_checked++;
		end
	end

	// watchdog, 40 cycles per command plus reset
	initial begin
		wait (list_ready);
		#((10 + 40 * cmd_list.size()) * 10);
		$display("timeout: only %0d of %0d results arrived", n_checked, cmd_list.size());
		$display("Some tests failed");
		$fatal(1, "timeout");
	end

	initial begin
		__ic_cu = 1'b0;
		__ic_load = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		res_credit = 1'b0;
		m_ac = '0;
		m_at = '0;
		m_ar = '0;
		m_ic = '0;
		sent = 0;
		n_checked = 0;
		build_tests();
		list_ready = 1'b1;
		repeat (10) @(posedge __ic_cu);
		__ic_load <= 1'b0;
		wait (n_checked == cmd_list.size());
		repeat (10) @(posedge __ic_cu);
		if (exp_q.size() == 0 && n_checked == cmd_list.size()) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("result count does not match the commands sent");
			$display("Some tests failed");
			$fatal(1, "count mismatch");
		end
	end

endmodule

// File: mera_pa.f
source/mera_pa_pkg.sv
source/pa_dp_if.sv
source/pa_bus_mux.sv
source/pa_alu.sv
source/pa_regs.sv
source/pa_control.sv
source/mera_pa_top.sv
dv/mera_pa_sva.sv
dv/mera_pa_tb.sv

// File: source/mera_pa_pkg.sv
/*
	shared types and sizes for the P-A arithmetic unit
	words keep the machine bit order, bit 0 is the MSB
	for load opcodes fn is reused as W bus control:
	  fn[0] blanks the low byte, fn[1] the high byte, fn[2] loads {8'h00, ac[0:7]}
	non-ALU results report s0 and zs of the value, carry and j read zero,
	zga is only set for op_cmp_addr
*/
package mera_pa_pkg;

	// command buffer entries, also the sender's credits after reset
	localparam int CMD_DEPTH = 2;
	localparam int RES_CREDITS = 2;

	localparam int CMD_PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);
	localparam int RES_CNT_W = $clog2(RES_CREDITS + 1);

	// A bus sources in cmd.asrc
	localparam logic [1:0] ASRC_L = 2'd0;
	localparam logic [1:0] ASRC_IC = 2'd1;
	localparam logic [1:0] ASRC_AR = 2'd2;
	// operand low byte moved to the high byte, low byte blanked
	localparam logic [1:0] ASRC_LH = 2'd3;

	typedef logic [0:15] word_t;

	typedef enum logic [3:0] {
		op_ld_ac,
		op_ld_ar,
		op_ld_ic,
		op_alu,
		op_alu_at,
		op_shr_at,
		op_ar_inc,
		op_ar_dec4,
		op_ic_inc,
		op_cmp_addr
	} pa_op_e;

	typedef struct packed {
		pa_op_e op;
		logic [3:0] fn;
		logic arith;
		logic cin;
		logic [1:0] asrc;
		logic aref;
		logic eat0;
		logic barnb;
		// reserved, keeps a command 32 bits wide
		logic rsvd;
		word_t operand;
	} cmd_t;

	typedef struct packed {
		word_t value;
		logic carry;
		logic zs;
		logic s0;
		logic j;
		logic zga;
	} res_t;

endpackage

// File: source/mera_pa_top.sv
/*
	P-A arithmetic unit top level
	plain credit channels outside, datapath selects on one interface inside
*/
`timescale 1ns/1ps

module mera_pa_top (
	input logic __ic_cu,
	input logic __ic_load,
	input logic cmd_valid,
	input mera_pa_pkg::cmd_t cmd,
	output logic cmd_credit,
	output logic res_valid,
	output mera_pa_pkg::res_t res,
	input logic res_credit
);

	mera_pa_pkg::word_t operand;
	mera_pa_pkg::word_t w_bus;
	mera_pa_pkg::word_t a_bus;
	mera_pa_pkg::word_t f;
	mera_pa_pkg::word_t ac;
	mera_pa_pkg::word_t at;
	mera_pa_pkg::word_t ar;
	mera_pa_pkg::word_t ic;
	mera_pa_pkg::word_t dad;
	logic carry;
	logic s0;
	logic j;
	logic zs;
	logic zga;

	pa_dp_if dp_if ();

	pa_control control_i (
		.__ic_cu(__ic_cu), .__ic_load(__ic_load),
		.cmd_valid(cmd_valid), .cmd(cmd), .res_credit(res_credit),
		.f(f), .carry(carry), .s0(s0), .j(j), .zs(zs),
		.ac(ac), .at(at), .ar(ar), .ic(ic), .dad(dad), .zga(zga),
		.cmd_credit(cmd_credit), .res_valid(res_valid), .res(res),
		.operand(operand), .dp(dp_if.ctrl)
	);

	pa_bus_mux bus_mux_i (
		.dp(dp_if.dp), .operand(operand), .ac(ac), .at(at), .ar(ar), .ic(ic),
		.w_bus(w_bus), .a_bus(a_bus)
	);

	pa_alu alu_i (
		.dp(dp_if.dp), .a_bus(a_bus), .ac(ac),
		.f(f), .carry(carry), .s0(s0), .j(j), .zs(zs)
	);

	// the key for the address compare is the command operand
	pa_regs regs_i (
		.__ic_cu(__ic_cu), .__ic_load(__ic_load), .dp(dp_if.dp),
		.w_bus(w_bus), .f(f), .key(operand),
		.ac(ac), .at(at), .ar(ar), .ic(ic), .dad(dad), .zga(zga)
	);

endmodule

// File: source/pa_alu.sv
/*
	16-bit ALU from four 74181-style slices and a 74182-style lookahead
	data and carry-in are active high, arith=1 selects arithmetic mode
	carry reads zero in logic mode
	j is the AND of the slice A=B outputs, so it means A equals AC
	only under A minus B minus 1 with cin low
*/
`timescale 1ns/1ps

module pa_alu (
	pa_dp_if.dp dp,
	input mera_pa_pkg::word_t a_bus,
	input mera_pa_pkg::word_t ac,
	output mera_pa_pkg::word_t f,
	output logic carry,
	output logic s0,
	output logic j,
	output logic zs
);

	// per slice group generate, propagate, carry in and equality
	logic [0:3] sg;
	logic [0:3] sp;
	logic [0:3] sc;
	logic [0:3] eq;

	// slice 0 holds bits 0..3, the most significant ones
	for (genvar s = 0; s < 4; s++) begin : g_slice
		logic [0:3] a4;
		logic [0:3] b4;
		logic [0:3] u4;
		logic [0:3] v4;
		logic [0:3] g4;
		logic [0:3] p4;
		logic [0:3] c4;
		logic [0:3] f4;

		assign a4 = a_bus[4*s +: 4];
		assign b4 = ac[4*s +: 4];

		// 74181 input gating, S0/S1 pick the B term, S2/S3 the A&B terms
		assign u4 = ~(a4 | (b4 & {4{dp.fn[0]}}) | (~b4 & {4{dp.fn[1]}}));
		assign v4 = ~((a4 & ~b4 & {4{dp.fn[2]}}) | (a4 & b4 & {4{dp.fn[3]}}));
		assign g4 = ~v4;
		assign p4 = ~u4;

		// ripple inside the slice, bit 3 is the lowest
		assign c4[3] = sc[s];
		assign c4[2] = g4[3] | (p4[3] & c4[3]);
		assign c4[1] = g4[2] | (p4[2] & c4[2]);
		assign c4[0] = g4[1] | (p4[1] & c4[1]);

		assign f4 = dp.arith ? (u4 ^ v4 ^ c4) : ~(u4 ^ v4);
		assign f[4*s +: 4] = f4;

		assign sg[s] = g4[0] | (p4[0] & g4[1]) | (p4[0] & p4[1] & g4[2])
			| (p4[0] & p4[1] & p4[2] & g4[3]);
		assign sp[s] = &p4;
		assign eq[s] = &f4;
	end

	// 74182 lookahead, slice 3 takes the external carry
	assign sc[3] = dp.cin;
	assign sc[2] = sg[3] | (sp[3] & dp.cin);
	assign sc[1] = sg[2] | (sp[2] & sg[3]) | (sp[2] & sp[3] & dp.cin);
	assign sc[0] = sg[1] | (sp[1] & sg[2]) | (sp[1] & sp[2] & sg[3])
		| (sp[1] & sp[2] & sp[3] & dp.cin);

	// carry out of the top slice
	assign carry = dp.arith & (sg[0] | (sp[0] & sc[0]));

	assign s0 = f[0];
	assign j = &eq;
	assign zs = |f;

endmodule

// File: source/pa_bus_mux.sv
/*
	W bus and A bus source selection, purely combinational
	no memory or key inputs here: ar and ic take the rdt and ki positions,
	the operand serves both as l/kl and in the instruction register position
*/
`timescale 1ns/1ps

module pa_bus_mux (
	pa_dp_if.dp dp,
	input mera_pa_pkg::word_t operand,
	input mera_pa_pkg::word_t ac,
	input mera_pa_pkg::word_t at,
	input mera_pa_pkg::word_t ar,
	input mera_pa_pkg::word_t ic,
	output mera_pa_pkg::word_t w_bus,
	output mera_pa_pkg::word_t a_bus
);

	mera_pa_pkg::word_t a_raw;
	mera_pa_pkg::word_t w_raw;

	// A bus, blanked in three fields
	always_comb begin
		case ({dp.ab, dp.aa})
			2'b00: a_raw = {operand[8:15], operand[8:15]};
			2'b01: a_raw = ic;
			2'b10: a_raw = ar;
			default: a_raw = operand;
		endcase
		a_bus = a_raw;
		if (dp.bac)
			a_bus[0:7] = 8'h00;
		if (dp.bab)
			a_bus[8:9] = 2'b00;
		if (dp.baa)
			a_bus[10:15] = 6'b000000;
	end

	// eight-way W bus, per-byte blanking afterwards
	always_comb begin
		case ({dp.mwa, dp.mwb, dp.mwc})
			3'b000, 3'b001: w_raw = operand;
			3'b010: w_raw = ar;
			// AC high byte lands in the low byte
			3'b011: w_raw = {8'h00, ac[0:7]};
			3'b100: w_raw = ic;
			3'b101: w_raw = at;
			3'b110: w_raw = ac;
			default: w_raw = a_bus;
		endcase
		w_bus = w_raw;
		if (dp.bwb)
			w_bus[0:7] = 8'h00;
		if (dp.bwa)
			w_bus[8:15] = 8'h00;
	end

endmodule

// File: source/pa_control.sv
/*
	command buffer, execute stage and result stage
	sender must hold a credit to assert cmd_valid, no overflow check here
	a command leaves the buffer into execute, the datapath updates
	at the end of execute, the result goes out the cycle after
	with no result credit the result is held and execute stalls
*/
`timescale 1ns/1ps

module pa_control (
	input logic __ic_cu,
	input logic __ic_load,
	input logic cmd_valid,
	input mera_pa_pkg::cmd_t cmd,
	input logic res_credit,
	input mera_pa_pkg::word_t f,
	input logic carry,
	input logic s0,
	input logic j,
	input logic zs,
	input mera_pa_pkg::word_t ac,
	input mera_pa_pkg::word_t at,
	input mera_pa_pkg::word_t ar,
	input mera_pa_pkg::word_t ic,
	input mera_pa_pkg::word_t dad,
	input logic zga,
	output logic cmd_credit,
	output logic res_valid,
	output mera_pa_pkg::res_t res,
	output mera_pa_pkg::word_t operand,
	pa_dp_if.ctrl dp
);

	mera_pa_pkg::cmd_t buf_q [mera_pa_pkg::CMD_DEPTH];
	logic [mera_pa_pkg::CMD_PTR_W-1:0] wr_ptr;
	logic [mera_pa_pkg::CMD_PTR_W-1:0] rd_ptr;
	logic [mera_pa_pkg::CMD_CNT_W-1:0] buf_cnt;
	logic [mera_pa_pkg::RES_CNT_W-1:0] res_cnt;
	mera_pa_pkg::cmd_t e_cmd;
	logic e_vld;
	logic r_vld;
	logic push;
	logic pop;
	logic fire;
	logic r_free;
	logic is_ld;
	logic is_alu;
	mera_pa_pkg::word_t ld_src;
	mera_pa_pkg::res_t res_d;

	assign push = cmd_valid;
	assign res_valid = r_vld && (res_cnt != '0);
	// result slot frees up when it is sent in this cycle
	assign r_free = !r_vld || res_valid;
	assign fire = e_vld && r_free;
	assign pop = (buf_cnt != '0) && (!e_vld || fire);

	always_ff @(posedge __ic_cu) begin
		if (push)
			buf_q[wr_ptr] <= cmd;
	end

	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			buf_cnt <= '0;
			e_vld <= 1'b0;
			r_vld <= 1'b0;
			res_cnt <= mera_pa_pkg::RES_CNT_W'(mera_pa_pkg::RES_CREDITS);
			cmd_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (int'(wr_ptr) == mera_pa_pkg::CMD_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (int'(rd_ptr) == mera_pa_pkg::CMD_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: buf_cnt <= buf_cnt + 1'b1;
				2'b01: buf_cnt <= buf_cnt - 1'b1;
				default: buf_cnt <= buf_cnt;
			endcase
			// credit goes back as the entry moves into execute
			cmd_credit <= pop;
			if (pop)
				e_vld <= 1'b1;
			else if (fire)
				e_vld <= 1'b0;
			if (fire)
				r_vld <= 1'b1;
			else if (res_valid)
				r_vld <= 1'b0;
			case ({res_valid, res_credit})
				2'b10: res_cnt <= res_cnt - 1'b1;
				2'b01: res_cnt <= res_cnt + 1'b1;
				default: res_cnt <= res_cnt;
			endcase
		end
	end

	always_ff @(posedge __ic_cu) begin
		if (pop)
			e_cmd <= buf_q[rd_ptr];
		if (fire)
			res <= res_d;
	end

	assign operand = e_cmd.operand;
	assign is_ld = e_cmd.op inside {mera_pa_pkg::op_ld_ac, mera_pa_pkg::op_ld_ar,
		mera_pa_pkg::op_ld_ic};
	assign is_alu = e_cmd.op inside {mera_pa_pkg::op_alu, mera_pa_pkg::op_alu_at};

	// one cycle of selects per command
	always_comb begin
		{dp.mwa, dp.mwb, dp.mwc} = (is_ld && e_cmd.fn[2]) ? 3'b011 : 3'b001;
		dp.bwa = is_ld & e_cmd.fn[0];
		dp.bwb = is_ld & e_cmd.fn[1];
		case (e_cmd.asrc)
			mera_pa_pkg::ASRC_IC: {dp.ab, dp.aa} = 2'b01;
			mera_pa_pkg::ASRC_AR: {dp.ab, dp.aa} = 2'b10;
			mera_pa_pkg::ASRC_LH: {dp.ab, dp.aa} = 2'b00;
			default: {dp.ab, dp.aa} = 2'b11;
		endcase
		// A bus quiet unless the ALU is in use
		dp.bac = !is_alu;
		dp.bab = !is_alu || (e_cmd.asrc == mera_pa_pkg::ASRC_LH);
		dp.baa = !is_alu || (e_cmd.asrc == mera_pa_pkg::ASRC_LH);
		dp.fn = e_cmd.fn;
		dp.arith = e_cmd.arith;
		dp.cin = e_cmd.cin;
		dp.w_ac = fire && (e_cmd.op == mera_pa_pkg::op_ld_ac);
		dp.w_ar = fire && (e_cmd.op == mera_pa_pkg::op_ld_ar);
		dp.w_ic = fire && (e_cmd.op == mera_pa_pkg::op_ld_ic);
		dp.w_at = fire && (e_cmd.op == mera_pa_pkg::op_alu_at);
		dp.at_shift = fire && (e_cmd.op == mera_pa_pkg::op_shr_at);
		dp.arp1 = fire && (e_cmd.op == mera_pa_pkg::op_ar_inc);
		dp.arm4 = fire && (e_cmd.op == mera_pa_pkg::op_ar_dec4);
		dp.icp1 = fire && (e_cmd.op == mera_pa_pkg::op_ic_inc);
		dp.eat0 = e_cmd.eat0;
		dp.ar_ad = e_cmd.aref;
		dp.barnb = e_cmd.barnb;
	end

	// new register contents, as the registers see them at the edge
	always_comb begin
		ld_src = e_cmd.fn[2] ? {8'h00, ac[0:7]} : e_cmd.operand;
		res_d = '0;
		case (e_cmd.op)
			mera_pa_pkg::op_ld_ac, mera_pa_pkg::op_ld_ar, mera_pa_pkg::op_ld_ic:
				res_d.value = {e_cmd.fn[1] ? 8'h00 : ld_src[0:7],
					e_cmd.fn[0] ? 8'h00 : ld_src[8:15]};
			mera_pa_pkg::op_alu, mera_pa_pkg::op_alu_at:
				res_d.value = f;
			mera_pa_pkg::op_shr_at: res_d.value = {e_cmd.eat0, at[0:14]};
			mera_pa_pkg::op_ar_inc: res_d.value = ar + 16'd1;
			mera_pa_pkg::op_ar_dec4: res_d.value = ar - 16'd4;
			mera_pa_pkg::op_ic_inc: res_d.value = ic + 16'd1;
			mera_pa_pkg::op_cmp_addr: res_d.value = dad;
			default: res_d.value = '0;
		endcase
		if (is_alu) begin
			res_d.carry = carry;
			res_d.zs = zs;
			res_d.s0 = s0;
			res_d.j = j;
		end else begin
			res_d.zs = |res_d.value;
			res_d.s0 = res_d.value[0];
		end
		res_d.zga = (e_cmd.op == mera_pa_pkg::op_cmp_addr) && zga;
	end

endmodule

// File: source/pa_dp_if.sv
/*
	datapath selects and strobes, driven by the controller
	strobes are single-cycle and already qualified by the controller
*/
`timescale 1ns/1ps

interface pa_dp_if;

	// W bus source and byte blanks
	logic mwa, mwb, mwc;
	logic bwa, bwb;
	// A bus source and blanks
	logic ab, aa;
	logic baa, bab, bac;
	// slice function select, S3..S0
	logic [3:0] fn;
	logic arith;
	logic cin;
	// register strobes
	logic w_ac, w_ar, w_ic, w_at;
	logic at_shift, arp1, arm4, icp1;
	logic eat0, ar_ad, barnb;

	modport ctrl (
		output mwa, mwb, mwc, bwa, bwb, ab, aa, baa, bab, bac,
		output fn, arith, cin, w_ac, w_ar, w_ic, w_at,
		output at_shift, arp1, arm4, icp1, eat0, ar_ad, barnb
	);

	modport dp (
		input mwa, mwb, mwc, bwa, bwb, ab, aa, baa, bab, bac,
		input fn, arith, cin, w_ac, w_ar, w_ic, w_at,
		input at_shift, arp1, arm4, icp1, eat0, ar_ad, barnb
	);

endinterface

// File: source/pa_regs.sv
/*
	AC, AT, AR and IC registers with the address output
	all four clear on reset, strobes act on the next clock edge
	only one strobe per register is expected in a cycle,
	a load wins over a counter step
*/
`timescale 1ns/1ps

module pa_regs (
	input logic __ic_cu,
	input logic __ic_load,
	pa_dp_if.dp dp,
	input mera_pa_pkg::word_t w_bus,
	input mera_pa_pkg::word_t f,
	input mera_pa_pkg::word_t key,
	output mera_pa_pkg::word_t ac,
	output mera_pa_pkg::word_t at,
	output mera_pa_pkg::word_t ar,
	output mera_pa_pkg::word_t ic,
	output mera_pa_pkg::word_t dad,
	output logic zga
);

	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load)
			ac <= '0;
		else if (dp.w_ac)
			ac <= w_bus;
	end

	// AT takes f or shifts right, eat0 entering at bit 0
	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load)
			at <= '0;
		else if (dp.w_at)
			at <= f;
		else if (dp.at_shift)
			at <= {dp.eat0, at[0:14]};
	end

	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load)
			ar <= '0;
		else if (dp.w_ar)
			ar <= w_bus;
		else if (dp.arm4)
			ar <= ar - 16'd4;
		else if (dp.arp1)
			ar <= ar + 16'd1;
	end

	always_ff @(posedge __ic_cu or posedge __ic_load) begin
		if (__ic_load)
			ic <= '0;
		else if (dp.w_ic)
			ic <= w_bus;
		else if (dp.icp1)
			ic <= ic + 16'd1;
	end

	assign dad = dp.ar_ad ? ar : ic;

	// key bit 0 is matched against barnb, not against the address
	assign zga = (dp.barnb == key[0]) && (key[1:15] == dad[1:15]);

endmodule
